// ==== Bender.yml ====
package:
  name: ex_stage

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/ex_pkg.sv
      - rtl/div_counter.sv
      - rtl/div_datapath.sv
      - rtl/hilo_reg.sv
      - rtl/ex_alu.sv
      - rtl/ex_mc_ctrl.sv
      - rtl/ex_stage_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/tb_ex_stage.sv

// ==== files.f ====
+incdir+rtl
rtl/ex_pkg.sv
rtl/div_counter.sv
rtl/div_datapath.sv
rtl/hilo_reg.sv
rtl/ex_alu.sv
rtl/ex_mc_ctrl.sv
rtl/ex_stage_top.sv
test/tb_ex_stage.sv

// ==== rtl/div_counter.sv ====
`timescale 1ns/100ps
`include "ex_defines.svh"

module div_counter (
    input  logic clk,
    input  logic rst_n_i,
    input  logic start_i,
    output logic step_en_o,
    output logic last_step_o
);
    localparam int CNT_W = $clog2(`EX_DIV_STEPS + 1);

    logic [CNT_W-1:0] cnt;
    logic             busy;

    // cnt 0 is the setup cycle after start, steps run on 1..EX_DIV_STEPS
    assign step_en_o   = busy && (cnt != '0);
    assign last_step_o = busy && (cnt == CNT_W'(`EX_DIV_STEPS));

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (start_i) begin
            busy <= 1'b1;
            cnt  <= '0;
        end else if (busy) begin
            busy <= !last_step_o;
            cnt  <= last_step_o ? '0 : cnt + 1'b1;
        end
    end

    a_no_restart: assert property (
        @(posedge clk) disable iff (!rst_n_i) start_i |-> !busy
    );

endmodule

// ==== rtl/div_datapath.sv ====
`timescale 1ns/100ps
`include "ex_defines.svh"

module div_datapath (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     start_i,
    input  logic                     signed_i,
    input  logic [`EX_REG_WIDTH-1:0] dividend_i,
    input  logic [`EX_REG_WIDTH-1:0] divisor_i,
    input  logic                     step_en_i,
    input  logic                     last_step_i,
    output logic                     div_done_o,
    output logic [`EX_REG_WIDTH-1:0] quot_o,
    output logic [`EX_REG_WIDTH-1:0] rem_o
);
    import ex_pkg::*;

    div_state_e               state;
    logic [`EX_REG_WIDTH-1:0] dvsr_mag;
    logic [`EX_REG_WIDTH-1:0] quot;       // dividend shifts out, quotient bits shift in
    logic [`EX_REG_WIDTH-1:0] rem;
    logic                     quot_neg;
    logic                     rem_neg;
    logic                     dvsr_zero;
    logic [`EX_REG_WIDTH:0]   rem_shift;
    logic [`EX_REG_WIDTH:0]   trial;

    assign rem_shift = {rem, quot[`EX_REG_WIDTH-1]};
    assign trial     = rem_shift - {1'b0, dvsr_mag};

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state <= DIV_IDLE;
        end else begin
            case (state)
                DIV_IDLE: if (start_i) state <= DIV_RUN;
                DIV_RUN:  if (step_en_i && last_step_i) state <= DIV_DONE;
                DIV_DONE: state <= DIV_IDLE;
                default:  state <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            quot      <= (signed_i && dividend_i[`EX_REG_WIDTH-1]) ? -dividend_i : dividend_i;
            dvsr_mag  <= (signed_i && divisor_i[`EX_REG_WIDTH-1]) ? -divisor_i : divisor_i;
            rem       <= `EX_ZERO_WORD;
            quot_neg  <= signed_i && (dividend_i[`EX_REG_WIDTH-1] ^ divisor_i[`EX_REG_WIDTH-1]);
            rem_neg   <= signed_i && dividend_i[`EX_REG_WIDTH-1];
            dvsr_zero <= (divisor_i == `EX_ZERO_WORD);
        end else if (step_en_i) begin
            if (!trial[`EX_REG_WIDTH]) begin             // fits, keep the difference
                rem  <= trial[`EX_REG_WIDTH-1:0];
                quot <= {quot[`EX_REG_WIDTH-2:0], 1'b1};
            end else begin                               // restore
                rem  <= rem_shift[`EX_REG_WIDTH-1:0];
                quot <= {quot[`EX_REG_WIDTH-2:0], 1'b0};
            end
        end
    end

    assign div_done_o = (state == DIV_DONE);

    // divide by zero leaves rem = |dividend|, so only the quotient needs forcing
    assign quot_o = dvsr_zero ? '1 : (quot_neg ? -quot : quot);
    assign rem_o  = rem_neg ? -rem : rem;          // remainder follows dividend sign

endmodule

// ==== rtl/ex_alu.sv ====
`timescale 1ns/100ps
`include "ex_defines.svh"

module ex_alu (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  ex_pkg::ex_issue_t        issue_i,
    input  logic                     accept_i,
    input  logic [`EX_REG_WIDTH-1:0] hi_i,
    input  logic [`EX_REG_WIDTH-1:0] lo_i,
    input  logic                     madd_first_i,
    input  logic                     madd_last_i,
    input  logic                     div_done_i,
    input  logic [`EX_REG_WIDTH-1:0] div_quot_i,
    input  logic [`EX_REG_WIDTH-1:0] div_rem_i,
    output ex_pkg::ex_result_t       result_o,
    output ex_pkg::hilo_wr_t         hilo_wr_o,
    output logic [`EX_REG_WIDTH-1:0] div_op1_o,
    output logic [`EX_REG_WIDTH-1:0] div_op2_o,
    output logic                     div_signed_o
);
    import ex_pkg::*;

    aluop_e                       op;
    logic [`EX_REG_WIDTH-1:0]     a;
    logic [`EX_REG_WIDTH-1:0]     b;
    logic [`EX_REG_WIDTH-1:0]     sum;
    logic [`EX_REG_WIDTH-1:0]     diff;
    logic [`EX_REG_WIDTH-1:0]     logic_res;
    logic [`EX_REG_WIDTH-1:0]     shift_res;
    logic [`EX_REG_WIDTH-1:0]     move_res;
    logic [`EX_REG_WIDTH-1:0]     arith_res;
    logic [`EX_REG_WIDTH-1:0]     alu_res;
    logic                         ov;
    logic                         reg_we_ex;
    logic                         mul_signed;
    logic signed [`EX_REG_WIDTH:0]     mul_a;
    logic signed [`EX_REG_WIDTH:0]     mul_b;
    logic signed [2*`EX_REG_WIDTH+1:0] mul_full;
    logic [2*`EX_REG_WIDTH-1:0]   prod;
    logic [2*`EX_REG_WIDTH-1:0]   madd_temp;   // product held between the two madd steps
    logic                         madd_sub;
    logic [2*`EX_REG_WIDTH-1:0]   hilo_acc;

    // run of leading bits equal to ones, scanning from the msb
    function automatic logic [5:0] lead_count(input logic [`EX_REG_WIDTH-1:0] val,
                                              input logic ones);
        logic [5:0] n;
        logic       stop;
        n    = '0;
        stop = 1'b0;
        for (int i = `EX_REG_WIDTH - 1; i >= 0; i--) begin
            if (!stop && val[i] == ones) begin
                n = n + 1'b1;
            end else begin
                stop = 1'b1;
            end
        end
        return n;
    endfunction

    assign op   = issue_i.aluop;
    assign a    = issue_i.op1;
    assign b    = issue_i.op2;
    assign sum  = a + b;
    assign diff = a - b;

    // one 33x33 signed multiplier serves mul, mult(u) and madd/msub(u)
    assign mul_signed = op inside {ALU_MUL_OP, ALU_MULT_OP, ALU_MADD_OP, ALU_MSUB_OP};
    assign mul_a      = {mul_signed & a[`EX_REG_WIDTH-1], a};
    assign mul_b      = {mul_signed & b[`EX_REG_WIDTH-1], b};
    assign mul_full   = mul_a * mul_b;
    assign prod       = mul_full[2*`EX_REG_WIDTH-1:0];

    always_comb begin
        logic_res = `EX_ZERO_WORD;
        shift_res = `EX_ZERO_WORD;
        move_res  = `EX_ZERO_WORD;
        case (op)
            ALU_OR_OP:   logic_res = a | b;
            ALU_AND_OP:  logic_res = a & b;
            ALU_XOR_OP:  logic_res = a ^ b;
            ALU_NOR_OP:  logic_res = ~(a | b);
            ALU_SLL_OP:  shift_res = a << b[4:0];        // sa or rs[4:0] arrives in op2
            ALU_SRL_OP:  shift_res = a >> b[4:0];
            ALU_SRA_OP:  shift_res = $signed(a) >>> b[4:0];
            ALU_MOVN_OP,
            ALU_MOVZ_OP: move_res  = a;
            ALU_MFHI_OP: move_res  = hi_i;
            ALU_MFLO_OP: move_res  = lo_i;
            default:     logic_res = `EX_ZERO_WORD;
        endcase
    end

    always_comb begin
        arith_res = `EX_ZERO_WORD;
        ov        = 1'b0;
        case (op)
            ALU_ADD_OP: begin
                arith_res = sum;
                ov = (~a[31] & ~b[31] & sum[31]) | (a[31] & b[31] & ~sum[31]);
            end
            ALU_SUB_OP: begin
                arith_res = diff;
                ov = (~a[31] & b[31] & diff[31]) | (a[31] & ~b[31] & ~diff[31]);
            end
            ALU_ADDU_OP: arith_res = sum;
            ALU_SUBU_OP: arith_res = diff;
            ALU_MUL_OP:  arith_res = prod[`EX_REG_WIDTH-1:0];   // low word only
            ALU_SLT_OP:  arith_res = `EX_REG_WIDTH'($signed(a) < $signed(b));
            ALU_SLTU_OP: arith_res = `EX_REG_WIDTH'(a < b);
            ALU_CLZ_OP:  arith_res = `EX_REG_WIDTH'(lead_count(a, 1'b0));
            ALU_CLO_OP:  arith_res = `EX_REG_WIDTH'(lead_count(a, 1'b1));
            default:     arith_res = `EX_ZERO_WORD;
        endcase
    end

    always_comb begin
        case (issue_i.alusel)
            ALU_RES_LOGIC:       alu_res = logic_res;
            ALU_RES_SHIFT:       alu_res = shift_res;
            ALU_RES_MOVE:        alu_res = move_res;
            ALU_RES_ARITHMETIC:  alu_res = arith_res;
            ALU_RES_JUMP_BRANCH: alu_res = issue_i.link_addr;
            ALU_RES_LOAD_STORE:  alu_res = sum;            // base + offset
            default:             alu_res = `EX_ZERO_WORD;
        endcase
    end

    always_comb begin
        reg_we_ex = issue_i.reg_we && !ov;                 // overflow drops the write
        case (op)
            ALU_MOVN_OP:  reg_we_ex = issue_i.reg_we && (b != `EX_ZERO_WORD);
            ALU_MOVZ_OP:  reg_we_ex = issue_i.reg_we && (b == `EX_ZERO_WORD);
            ALU_MTHI_OP, ALU_MTLO_OP, ALU_MULT_OP, ALU_MULTU_OP,
            ALU_MADD_OP, ALU_MADDU_OP, ALU_MSUB_OP, ALU_MSUBU_OP,
            ALU_DIV_OP, ALU_DIVU_OP:
                          reg_we_ex = 1'b0;                // hi/lo only
            default:      reg_we_ex = issue_i.reg_we && !ov;
        endcase
    end

    always_ff @(posedge clk) begin
        if (madd_first_i) begin
            madd_temp <= prod;
            madd_sub  <= op inside {ALU_MSUB_OP, ALU_MSUBU_OP};
        end
    end

    assign hilo_acc = madd_sub ? {hi_i, lo_i} - madd_temp : {hi_i, lo_i} + madd_temp;

    always_comb begin
        hilo_wr_o = '0;
        if (madd_last_i) begin
            hilo_wr_o.hi_we = 1'b1;
            hilo_wr_o.lo_we = 1'b1;
            {hilo_wr_o.hi, hilo_wr_o.lo} = hilo_acc;
        end else if (div_done_i) begin
            hilo_wr_o.hi_we = 1'b1;
            hilo_wr_o.lo_we = 1'b1;
            hilo_wr_o.hi    = div_rem_i;
            hilo_wr_o.lo    = div_quot_i;
        end else if (accept_i) begin
            case (op)
                ALU_MTHI_OP: begin
                    hilo_wr_o.hi_we = 1'b1;
                    hilo_wr_o.hi    = a;
                end
                ALU_MTLO_OP: begin
                    hilo_wr_o.lo_we = 1'b1;
                    hilo_wr_o.lo    = a;
                end
                ALU_MULT_OP, ALU_MULTU_OP: begin
                    hilo_wr_o.hi_we = 1'b1;
                    hilo_wr_o.lo_we = 1'b1;
                    {hilo_wr_o.hi, hilo_wr_o.lo} = prod;
                end
                default: hilo_wr_o = '0;
            endcase
        end
    end

    assign div_op1_o    = a;
    assign div_op2_o    = b;
    assign div_signed_o = (op == ALU_DIV_OP);

    // EX/MEM register
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            result_o <= '0;
        end else if (accept_i) begin
            result_o.waddr   <= issue_i.waddr;
            result_o.reg_we  <= reg_we_ex;
            result_o.alu_res <= alu_res;
        end else begin
            result_o <= '0;                                // bubble
        end
    end

endmodule

// ==== rtl/ex_defines.svh ====
`ifndef EX_DEFINES_SVH
`define EX_DEFINES_SVH

// mips32 data path is one word wide
`define EX_REG_WIDTH 32

// restoring divider retires one quotient bit per step
`define EX_DIV_STEPS 32

`define EX_ZERO_WORD 32'h0000_0000

`endif

// ==== rtl/ex_mc_ctrl.sv ====
`timescale 1ns/100ps

module ex_mc_ctrl (
    input  logic           clk,
    input  logic           rst_n_i,
    input  logic           issue_valid_i,
    input  ex_pkg::aluop_e aluop_i,
    input  logic           div_done_i,
    output logic           madd_first_o,
    output logic           madd_last_o,
    output logic           div_start_o,
    output logic           stall_o,
    output logic           accept_o
);
    import ex_pkg::*;

    mc_state_e state;
    logic      is_madd;
    logic      is_div;

    assign is_madd = aluop_i inside {ALU_MADD_OP, ALU_MADDU_OP, ALU_MSUB_OP, ALU_MSUBU_OP};
    assign is_div  = aluop_i inside {ALU_DIV_OP, ALU_DIVU_OP};

    assign stall_o      = (state != MC_IDLE);
    assign accept_o     = issue_valid_i && !stall_o;
    assign madd_first_o = accept_o && is_madd;      // product capture
    assign div_start_o  = accept_o && is_div;       // divider loads operands here
    assign madd_last_o  = (state == MC_MADD_ACC);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state <= MC_IDLE;
        end else begin
            case (state)
                MC_IDLE: begin
                    if (madd_first_o) begin
                        state <= MC_MADD_ACC;
                    end else if (div_start_o) begin
                        state <= MC_DIV_WAIT;
                    end
                end
                MC_MADD_ACC: state <= MC_IDLE;      // accumulate lands this edge
                MC_DIV_WAIT: begin
                    if (div_done_i) begin
                        state <= MC_IDLE;
                    end
                end
                default: state <= MC_IDLE;
            endcase
        end
    end

    // longest stall is a divide: start, 32 steps, done
    a_stall_bound: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        $rose(stall_o) |-> ##[1:34] !stall_o
    );

endmodule

// ==== rtl/ex_pkg.sv ====
`include "ex_defines.svh"

package ex_pkg;

    // decoded operation, one code per instruction flavour
    typedef enum logic [5:0] {
        ALU_NOP_OP,
        ALU_OR_OP,
        ALU_AND_OP,
        ALU_XOR_OP,
        ALU_NOR_OP,
        ALU_SLL_OP,
        ALU_SRL_OP,
        ALU_SRA_OP,
        ALU_MOVN_OP,
        ALU_MOVZ_OP,
        ALU_MFHI_OP,
        ALU_MFLO_OP,
        ALU_ADD_OP,
        ALU_ADDU_OP,
        ALU_SUB_OP,
        ALU_SUBU_OP,
        ALU_MUL_OP,
        ALU_SLT_OP,
        ALU_SLTU_OP,
        ALU_CLZ_OP,
        ALU_CLO_OP,
        ALU_MTHI_OP,
        ALU_MTLO_OP,
        ALU_MULT_OP,
        ALU_MULTU_OP,
        ALU_MADD_OP,
        ALU_MADDU_OP,
        ALU_MSUB_OP,
        ALU_MSUBU_OP,
        ALU_DIV_OP,
        ALU_DIVU_OP
    } aluop_e;

    typedef enum logic [2:0] {
        ALU_RES_NOP,
        ALU_RES_LOGIC,
        ALU_RES_SHIFT,
        ALU_RES_MOVE,
        ALU_RES_ARITHMETIC,
        ALU_RES_JUMP_BRANCH,
        ALU_RES_LOAD_STORE
    } alusel_e;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_DONE
    } div_state_e;

    typedef enum logic [1:0] {
        MC_IDLE,
        MC_MADD_ACC,
        MC_DIV_WAIT
    } mc_state_e;

    typedef struct packed {
        aluop_e                   aluop;
        alusel_e                  alusel;
        logic [`EX_REG_WIDTH-1:0] op1;
        logic [`EX_REG_WIDTH-1:0] op2;
        logic [4:0]               waddr;
        logic                     reg_we;
        logic [`EX_REG_WIDTH-1:0] link_addr; // return address for jal/jalr/bal
    } ex_issue_t;

    typedef struct packed {
        logic [4:0]               waddr;
        logic                     reg_we;
        logic [`EX_REG_WIDTH-1:0] alu_res; // gpr data or memory address
    } ex_result_t;

    typedef struct packed {
        logic                     hi_we;
        logic                     lo_we;
        logic [`EX_REG_WIDTH-1:0] hi;
        logic [`EX_REG_WIDTH-1:0] lo;
    } hilo_wr_t;

endpackage

// ==== rtl/ex_stage_top.sv ====
`timescale 1ns/100ps
`include "ex_defines.svh"

module ex_stage_top (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  ex_pkg::ex_issue_t        issue_i,
    input  logic                     issue_valid_i,
    output ex_pkg::ex_result_t       result_o,
    output logic [`EX_REG_WIDTH-1:0] hi_o,
    output logic [`EX_REG_WIDTH-1:0] lo_o,
    output logic                     stall_o
);
    import ex_pkg::*;

    hilo_wr_t                 hilo_wr;
    logic                     accept;
    logic                     madd_first;
    logic                     madd_last;
    logic                     div_start;
    logic                     div_done;
    logic                     div_signed;
    logic [`EX_REG_WIDTH-1:0] div_op1;
    logic [`EX_REG_WIDTH-1:0] div_op2;
    logic [`EX_REG_WIDTH-1:0] div_quot;
    logic [`EX_REG_WIDTH-1:0] div_rem;
    logic                     step_en;
    logic                     last_step;

    ex_alu u_ex_alu (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .issue_i      (issue_i),
        .accept_i     (accept),
        .hi_i         (hi_o),
        .lo_i         (lo_o),
        .madd_first_i (madd_first),
        .madd_last_i  (madd_last),
        .div_done_i   (div_done),
        .div_quot_i   (div_quot),
        .div_rem_i    (div_rem),
        .result_o     (result_o),
        .hilo_wr_o    (hilo_wr),
        .div_op1_o    (div_op1),
        .div_op2_o    (div_op2),
        .div_signed_o (div_signed)
    );

    ex_mc_ctrl u_ex_mc_ctrl (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .issue_valid_i (issue_valid_i),
        .aluop_i       (issue_i.aluop),
        .div_done_i    (div_done),
        .madd_first_o  (madd_first),
        .madd_last_o   (madd_last),
        .div_start_o   (div_start),
        .stall_o       (stall_o),
        .accept_o      (accept)
    );

    div_counter u_div_counter (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .start_i     (div_start),
        .step_en_o   (step_en),
        .last_step_o (last_step)
    );

    div_datapath u_div_datapath (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .start_i     (div_start),
        .signed_i    (div_signed),
        .dividend_i  (div_op1),
        .divisor_i   (div_op2),
        .step_en_i   (step_en),
        .last_step_i (last_step),
        .div_done_o  (div_done),
        .quot_o      (div_quot),
        .rem_o       (div_rem)
    );

    hilo_reg u_hilo_reg (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .wr_i    (hilo_wr),
        .hi_o    (hi_o),
        .lo_o    (lo_o)
    );

endmodule

// ==== rtl/hilo_reg.sv ====
`timescale 1ns/100ps
`include "ex_defines.svh"

module hilo_reg (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  ex_pkg::hilo_wr_t         wr_i,
    output logic [`EX_REG_WIDTH-1:0] hi_o,
    output logic [`EX_REG_WIDTH-1:0] lo_o
);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            hi_o <= `EX_ZERO_WORD;
            lo_o <= `EX_ZERO_WORD;
        end else begin
            if (wr_i.hi_we) begin
                hi_o <= wr_i.hi;
            end
            if (wr_i.lo_we) begin
                lo_o <= wr_i.lo;
            end
        end
    end

endmodule

// ==== test/tb_ex_stage.sv ====
`timescale 1ns/100ps
`include "ex_defines.svh"

module tb_ex_stage;
    import ex_pkg::*;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 8;
    localparam int RAND_OPS     = 200;
    localparam int HILO_OPS     = 40;
    localparam int MADD_OPS     = 40;
    localparam int DIV_OPS      = 40;
    localparam int MIX_OPS      = 30;
    localparam int DIV_CYCLES   = 34;  // start, 32 steps, done
    localparam int MAX_CYCLES   = RESET_CYCLES + 2 * (RAND_OPS + HILO_OPS) + 3 * MADD_OPS
                                + (DIV_CYCLES + 2) * (DIV_OPS + 3 + MIX_OPS) + 300;

    logic                     clk;
    logic                     rst_n_i;
    ex_issue_t                issue_i;
    logic                     issue_valid_i;
    ex_result_t               result_o;
    logic [`EX_REG_WIDTH-1:0] hi_o;
    logic [`EX_REG_WIDTH-1:0] lo_o;
    logic                     stall_o;

    logic [31:0] lfsr;
    int          checks;
    int          errors;
    int          test_chk0;
    int          test_err0;
    aluop_e      pool[$];      // opcodes the current test draws from
    logic [31:0] m_hi;         // model hi/lo
    logic [31:0] m_lo;
    logic [63:0] pend_pair;    // {hi, lo} that lands when the stall ends
    int          left;         // model stall cycles still to go
    logic        acc_pend;     // taken at the coming edge
    ex_issue_t   acc_ins;
    ex_result_t  exp_res;

    ex_stage_top u_ex_stage_top (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .issue_i       (issue_i),
        .issue_valid_i (issue_valid_i),
        .result_o      (result_o),
        .hi_o          (hi_o),
        .lo_o          (lo_o),
        .stall_o       (stall_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(MAX_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the DUT stopped making progress",
                 MAX_CYCLES);
        $display("Test failures found");
        $finish;
    end

    function automatic logic next_bit();
        logic lsb;
        lsb  = lfsr[0];
        lfsr = {1'b0, lfsr[31:1]} ^ (lsb ? 32'h8020_0003 : 32'h0);  // x^32+x^22+x^2+x+1
        return lsb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], next_bit()};
        end
        return v;
    endfunction

    function automatic logic [31:0] rand_operand();
        logic [2:0] kind;
        kind = rand_bits(3);
        case (kind)
            3'd0:    return 32'h7fff_ffff - rand_bits(2);     // near the signed limits
            3'd1:    return 32'h8000_0000 + rand_bits(2);
            3'd2:    return rand_bits(32) >> rand_bits(5);    // long zero runs
            3'd3:    return ~(rand_bits(32) >> rand_bits(5)); // long one runs
            3'd4:    return '0;
            default: return rand_bits(32);
        endcase
    endfunction

    function automatic alusel_e sel_for(input aluop_e op);
        case (op)
            ALU_OR_OP, ALU_AND_OP, ALU_XOR_OP, ALU_NOR_OP:
                return ALU_RES_LOGIC;
            ALU_SLL_OP, ALU_SRL_OP, ALU_SRA_OP:
                return ALU_RES_SHIFT;
            ALU_MOVN_OP, ALU_MOVZ_OP, ALU_MFHI_OP, ALU_MFLO_OP:
                return ALU_RES_MOVE;
            ALU_ADD_OP, ALU_ADDU_OP, ALU_SUB_OP, ALU_SUBU_OP, ALU_MUL_OP,
            ALU_SLT_OP, ALU_SLTU_OP, ALU_CLZ_OP, ALU_CLO_OP:
                return ALU_RES_ARITHMETIC;
            default:
                return ALU_RES_NOP;
        endcase
    endfunction

    function automatic ex_issue_t make_op(input aluop_e op);
        ex_issue_t ins;
        ins.aluop  = op;
        ins.alusel = sel_for(op);
        if (op == ALU_NOP_OP) begin   // nop stands for a link or an address calculation
            ins.alusel = next_bit() ? ALU_RES_JUMP_BRANCH : ALU_RES_LOAD_STORE;
        end
        ins.op1       = rand_operand();
        ins.op2       = rand_operand();
        ins.waddr     = rand_bits(5);
        ins.reg_we    = (rand_bits(2) != 0);
        ins.link_addr = rand_bits(32);
        return ins;
    endfunction

    function automatic ex_issue_t fixed_op(input aluop_e op, input logic [31:0] a,
                                           input logic [31:0] b);
        ex_issue_t ins;
        ins     = make_op(op);
        ins.op1 = a;
        ins.op2 = b;
        return ins;
    endfunction

    function automatic logic [31:0] leading_run(input logic [31:0] v, input logic ones);
        int n;
        n = 0;
        while (n < 32 && v[31-n] == ones) begin
            n++;
        end
        return 32'(n);
    endfunction

    function automatic ex_result_t model_result(input ex_issue_t ins, input logic [31:0] hi,
                                                input logic [31:0] lo);
        ex_result_t         r;
        logic [31:0]        a;
        logic [31:0]        b;
        logic [32:0]        wide;
        logic signed [63:0] ps;
        logic               we;
        a  = ins.op1;
        b  = ins.op2;
        ps = $signed(a) * $signed(b);
        we = ins.reg_we;
        r  = '0;
        case (ins.alusel)
            ALU_RES_LOGIC: begin
                case (ins.aluop)
                    ALU_OR_OP:  r.alu_res = a | b;
                    ALU_AND_OP: r.alu_res = a & b;
                    ALU_XOR_OP: r.alu_res = a ^ b;
                    ALU_NOR_OP: r.alu_res = ~(a | b);
                    default:    r.alu_res = '0;
                endcase
            end
            ALU_RES_SHIFT: begin
                case (ins.aluop)
                    ALU_SLL_OP: r.alu_res = a << b[4:0];
                    ALU_SRL_OP: r.alu_res = a >> b[4:0];
                    ALU_SRA_OP: r.alu_res = $signed(a) >>> b[4:0];
                    default:    r.alu_res = '0;
                endcase
            end
            ALU_RES_MOVE: begin
                case (ins.aluop)
                    ALU_MOVN_OP: begin
                        r.alu_res = a;
                        we        = we && (b != '0);
                    end
                    ALU_MOVZ_OP: begin
                        r.alu_res = a;
                        we        = we && (b == '0);
                    end
                    ALU_MFHI_OP: r.alu_res = hi;
                    ALU_MFLO_OP: r.alu_res = lo;
                    default:     r.alu_res = '0;
                endcase
            end
            ALU_RES_ARITHMETIC: begin
                case (ins.aluop)
                    ALU_ADD_OP: begin
                        wide      = {a[31], a} + {b[31], b};
                        r.alu_res = wide[31:0];
                        we        = we && (wide[32] == wide[31]);  // no write on overflow
                    end
                    ALU_SUB_OP: begin
                        wide      = {a[31], a} - {b[31], b};
                        r.alu_res = wide[31:0];
                        we        = we && (wide[32] == wide[31]);
                    end
                    ALU_ADDU_OP: r.alu_res = a + b;
                    ALU_SUBU_OP: r.alu_res = a - b;
                    ALU_MUL_OP:  r.alu_res = ps[31:0];
                    ALU_SLT_OP:  r.alu_res = {31'b0, $signed(a) < $signed(b)};
                    ALU_SLTU_OP: r.alu_res = {31'b0, a < b};
                    ALU_CLZ_OP:  r.alu_res = leading_run(a, 1'b0);
                    ALU_CLO_OP:  r.alu_res = leading_run(a, 1'b1);
                    default:     r.alu_res = '0;
                endcase
            end
            ALU_RES_JUMP_BRANCH: r.alu_res = ins.link_addr;
            ALU_RES_LOAD_STORE:  r.alu_res = a + b;
            default:             r.alu_res = '0;
        endcase
        if (ins.aluop inside {ALU_MTHI_OP, ALU_MTLO_OP, ALU_MULT_OP, ALU_MULTU_OP,
                              ALU_MADD_OP, ALU_MADDU_OP, ALU_MSUB_OP, ALU_MSUBU_OP,
                              ALU_DIV_OP, ALU_DIVU_OP}) begin
            we = 1'b0;
        end
        r.waddr  = ins.waddr;
        r.reg_we = we;
        return r;
    endfunction

    // returns {remainder, quotient}
    function automatic logic [63:0] div_model(input logic [31:0] a, input logic [31:0] b,
                                              input logic sgn);
        logic [31:0] am;
        logic [31:0] bm;
        logic [31:0] q;
        logic [31:0] r;
        if (b == '0) begin
            return {a, 32'hffff_ffff};
        end
        am = (sgn && a[31]) ? -a : a;
        bm = (sgn && b[31]) ? -b : b;
        q  = am / bm;
        r  = am % bm;
        if (sgn && (a[31] != b[31])) begin
            q = -q;
        end
        if (sgn && a[31]) begin
            r = -r;
        end
        return {r, q};
    endfunction

    task automatic apply_hilo(input ex_issue_t ins);
        logic signed [63:0] ps;
        logic [63:0]        pu;
        logic [31:0]        a;
        logic [31:0]        b;
        a  = ins.op1;
        b  = ins.op2;
        ps = $signed(a) * $signed(b);
        pu = a * b;
        case (ins.aluop)
            ALU_MTHI_OP:  m_hi = a;
            ALU_MTLO_OP:  m_lo = a;
            ALU_MULT_OP:  {m_hi, m_lo} = ps;
            ALU_MULTU_OP: {m_hi, m_lo} = pu;
            ALU_MADD_OP:  pend_pair = {m_hi, m_lo} + ps;
            ALU_MADDU_OP: pend_pair = {m_hi, m_lo} + pu;
            ALU_MSUB_OP:  pend_pair = {m_hi, m_lo} - ps;
            ALU_MSUBU_OP: pend_pair = {m_hi, m_lo} - pu;
            ALU_DIV_OP:   pend_pair = div_model(a, b, 1'b1);
            ALU_DIVU_OP:  pend_pair = div_model(a, b, 1'b0);
            default:      pend_pair = pend_pair;
        endcase
        if (ins.aluop inside {ALU_MADD_OP, ALU_MADDU_OP, ALU_MSUB_OP, ALU_MSUBU_OP}) begin
            left = 1;
        end else if (ins.aluop inside {ALU_DIV_OP, ALU_DIVU_OP}) begin
            left = DIV_CYCLES;
        end
    endtask

    task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("MISMATCH at %0t: %s expected %0h, got %0h", $time, name, exp, act);
        end
    endtask

    // model steps across the rising edge just passed and then checks the DUT
    always @(negedge clk) begin
        if (rst_n_i) begin
            if (acc_pend) begin
                exp_res = model_result(acc_ins, m_hi, m_lo);
                apply_hilo(acc_ins);
            end else begin
                exp_res = '0;                  // bubble
                if (left > 0) begin
                    left = left - 1;
                    if (left == 0) begin
                        {m_hi, m_lo} = pend_pair;
                    end
                end
            end
            compare("result_o.waddr", exp_res.waddr, result_o.waddr);
            compare("result_o.reg_we", exp_res.reg_we, result_o.reg_we);
            compare("result_o.alu_res", exp_res.alu_res, result_o.alu_res);
            compare("stall_o", left > 0, stall_o);
            compare("hi_o", m_hi, hi_o);
            compare("lo_o", m_lo, lo_o);
            acc_pend = issue_valid_i && (left == 0);
            acc_ins  = issue_i;
        end
    end

    // returns on the falling edge before the edge that takes ins
    task automatic send_op(input ex_issue_t ins);
        @(posedge clk);
        issue_i       <= ins;
        issue_valid_i <= 1'b1;
        @(negedge clk);
        while (stall_o) begin
            @(negedge clk);
        end
    endtask

    task automatic run_random(input int n);
        for (int i = 0; i < n; i++) begin
            send_op(make_op(pool[rand_bits(8) % pool.size()]));
        end
    endtask

    task automatic open_test();
        test_chk0 = checks;
        test_err0 = errors;
    endtask

    task automatic close_test(input string name);
        @(posedge clk);
        issue_valid_i <= 1'b0;
        @(negedge clk);
        while (stall_o) begin
            @(negedge clk);
        end
        @(negedge clk);
        @(posedge clk);                // falling-edge checks have settled
        $display("%-8s %0d checks, %0d failed", name, checks - test_chk0, errors - test_err0);
    endtask

    initial begin
        lfsr          = 32'd21523;
        checks        = 0;
        errors        = 0;
        m_hi          = '0;
        m_lo          = '0;
        pend_pair     = '0;
        left          = 0;
        acc_pend      = 1'b0;
        acc_ins       = '0;
        rst_n_i       = 1'b0;
        issue_valid_i = 1'b0;
        issue_i       = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n_i <= 1'b1;

        open_test();
        @(negedge clk);
        @(negedge clk);
        close_test("reset");

        open_test();
        pool = '{ALU_OR_OP, ALU_AND_OP, ALU_XOR_OP, ALU_NOR_OP, ALU_SLL_OP, ALU_SRL_OP,
                 ALU_SRA_OP, ALU_MOVN_OP, ALU_MOVZ_OP, ALU_MFHI_OP, ALU_MFLO_OP,
                 ALU_ADD_OP, ALU_ADDU_OP, ALU_SUB_OP, ALU_SUBU_OP, ALU_MUL_OP,
                 ALU_SLT_OP, ALU_SLTU_OP, ALU_CLZ_OP, ALU_CLO_OP, ALU_NOP_OP, ALU_NOP_OP};
        run_random(RAND_OPS);
        close_test("single");

        open_test();
        pool = '{ALU_MTHI_OP, ALU_MTLO_OP, ALU_MULT_OP, ALU_MULTU_OP, ALU_MFHI_OP,
                 ALU_MFLO_OP};
        run_random(HILO_OPS);
        close_test("hilo");

        open_test();
        pool = '{ALU_MTHI_OP, ALU_MTLO_OP, ALU_MADD_OP, ALU_MADDU_OP, ALU_MSUB_OP,
                 ALU_MSUBU_OP};
        run_random(MADD_OPS);
        close_test("madd");

        open_test();
        send_op(fixed_op(ALU_DIV_OP, 32'h8000_0000, 32'hffff_ffff));  // most negative by -1
        send_op(fixed_op(ALU_DIV_OP, 32'hffff_fff9, 32'h0000_0000));
        send_op(fixed_op(ALU_DIVU_OP, 32'h8765_4321, 32'h0000_0000));
        pool = '{ALU_DIV_OP, ALU_DIVU_OP};
        run_random(DIV_OPS);
        close_test("divide");

        // next op sits on the inputs for the whole stall
        open_test();
        pool = '{ALU_MADD_OP, ALU_MSUBU_OP, ALU_DIV_OP, ALU_DIVU_OP, ALU_MTHI_OP,
                 ALU_MULT_OP, ALU_MFHI_OP, ALU_MFLO_OP, ALU_ADD_OP, ALU_MADDU_OP};
        run_random(MIX_OPS);
        close_test("held");

        $display("%0d checks, %0d failed", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
